/* Bender.yml */
package:
  name: fml_ddr3_bridge

sources:
  - logic/fml_ddr_pkg.sv
  - logic/fml_burst_port.sv
  - logic/app_cmd_sequencer.sv
  - logic/app_wdf_writer.sv
  - logic/fml_ddr3_bridge.sv
  - target: simulation
    files:
      - verification/mig_app_model.sv
      - verification/tb_fml_ddr3_bridge.sv

/* logic/app_cmd_sequencer.sv */
`timescale 1ns/1ns

/* Issues one controller command per FML burst once calibration is done,
   and reports write completion after both command and data are taken. */
module app_cmd_sequencer (
  input  logic                                   ddr_clk,
  input  logic                                   ddr_rst,
  input  logic [fml_ddr_pkg::app_addr_width-1:0] line_addr,
  input  logic                                   rd_start,
  input  logic                                   wr_start,
  input  logic                                   wdf_done,
  input  logic                                   app_rdy,
  input  logic                                   phy_init_done,
  output logic [fml_ddr_pkg::app_addr_width-1:0] app_addr,
  output fml_ddr_pkg::app_cmd_e                  app_cmd,
  output logic                                   app_en,
  output logic                                   wr_done
);

  fml_ddr_pkg::seq_state_e state;

  // Write data may be taken before the command is
  logic wdf_seen;
  logic cmd_accept;
  logic burst_start;

  assign cmd_accept  = app_en && app_rdy;
  assign burst_start = (state == fml_ddr_pkg::seq_idle) && (rd_start || wr_start);

  // ----------------------------------------
  // Command FSM
  // ----------------------------------------
  always_ff @(posedge ddr_clk) begin
    if (ddr_rst) begin
      state    <= fml_ddr_pkg::seq_idle;
      app_en   <= 1'b0;
      wr_done  <= 1'b0;
      wdf_seen <= 1'b0;
    end else begin
      wr_done <= 1'b0;
      if (wdf_done) begin
        wdf_seen <= 1'b1;
      end
      case (state)
        fml_ddr_pkg::seq_idle: begin
          if (rd_start || wr_start) begin
            // Held back until the PHY is calibrated
            app_en <= phy_init_done;
            state  <= fml_ddr_pkg::seq_cmd;
          end
        end
        fml_ddr_pkg::seq_cmd: begin
          if (cmd_accept) begin
            app_en <= 1'b0;
            if (app_cmd == fml_ddr_pkg::app_cmd_read) begin
              state <= fml_ddr_pkg::seq_idle;
            end else begin
              state <= fml_ddr_pkg::seq_wr_wait;
            end
          end else if (phy_init_done) begin
            app_en <= 1'b1;
          end
        end
        fml_ddr_pkg::seq_wr_wait: begin
          if (wdf_seen || wdf_done) begin
            wr_done  <= 1'b1;
            wdf_seen <= 1'b0;
            state    <= fml_ddr_pkg::seq_idle;
          end
        end
        default: begin
          state <= fml_ddr_pkg::seq_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Command payload
  // ----------------------------------------
  always_ff @(posedge ddr_clk) begin
    if (burst_start) begin
      app_addr <= line_addr;
      if (rd_start) begin
        app_cmd <= fml_ddr_pkg::app_cmd_read;
      end else begin
        app_cmd <= fml_ddr_pkg::app_cmd_write;
      end
    end
  end

  // Pending command stays put under back-pressure
  cmd_hold: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (app_en && !app_rdy) |=> (app_en && $stable(app_addr) && $stable(app_cmd)));

endmodule

/* logic/app_wdf_writer.sv */
`timescale 1ns/1ns

/* Drives the controller write-data channel. A packed line and mask are
   presented on wr_start and held until the controller takes them. */
module app_wdf_writer (
  input  logic                                   ddr_clk,
  input  logic                                   ddr_rst,
  input  logic                                   wr_start,
  input  logic [fml_ddr_pkg::app_data_width-1:0] wr_line,
  input  logic [fml_ddr_pkg::app_mask_width-1:0] wr_mask,
  input  logic                                   app_wdf_rdy,
  output logic [fml_ddr_pkg::app_data_width-1:0] app_wdf_data,
  output logic [fml_ddr_pkg::app_mask_width-1:0] app_wdf_mask,
  output logic                                   app_wdf_wren,
  output logic                                   app_wdf_end,
  output logic                                   wdf_done
);

  logic wdf_accept;

  assign wdf_accept = app_wdf_wren && app_wdf_rdy;

  // ----------------------------------------
  // Write strobe control
  // ----------------------------------------
  always_ff @(posedge ddr_clk) begin
    if (ddr_rst) begin
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
      wdf_done     <= 1'b0;
    end else begin
      wdf_done <= 1'b0;
      if (wr_start) begin
        // Whole burst fits in one app word
        app_wdf_wren <= 1'b1;
        app_wdf_end  <= 1'b1;
      end else if (wdf_accept) begin
        app_wdf_wren <= 1'b0;
        app_wdf_end  <= 1'b0;
        wdf_done     <= 1'b1;
      end
    end
  end

  // Line and mask
  always_ff @(posedge ddr_clk) begin
    if (wr_start) begin
      app_wdf_data <= wr_line;
      app_wdf_mask <= wr_mask;
    end
  end

  // Single-word bursts only
  wren_end_match: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    app_wdf_wren == app_wdf_end);

  // Data held while the controller stalls
  wdf_hold: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (app_wdf_wren && !app_wdf_rdy) |=>
      (app_wdf_wren && $stable(app_wdf_data) && $stable(app_wdf_mask)));

endmodule

/* logic/fml_burst_port.sv */
`timescale 1ns/1ns

/* FML slave side of the bridge. Packs write beats into a 256-bit line with
   its byte mask, and replays a captured read line as wrapped beats. */
module fml_burst_port (
  input  logic                                   ddr_clk,
  input  logic                                   ddr_rst,
  input  logic [fml_ddr_pkg::fml_adr_width-1:0]  fml_adr,
  input  logic                                   fml_stb,
  input  logic                                   fml_we,
  input  logic [fml_ddr_pkg::sel_width-1:0]      fml_sel,
  output logic                                   fml_ack,
  output logic [fml_ddr_pkg::beat_width-1:0]     fml_do,
  input  logic [fml_ddr_pkg::beat_width-1:0]     fml_di,
  input  logic [fml_ddr_pkg::app_data_width-1:0] app_rd_data,
  input  logic                                   app_rd_data_valid,
  input  logic                                   app_rd_data_end,
  input  logic                                   wr_done,
  output logic [fml_ddr_pkg::app_addr_width-1:0] line_addr,
  output logic                                   rd_start,
  output logic                                   wr_start,
  output logic [fml_ddr_pkg::app_data_width-1:0] wr_line,
  output logic [fml_ddr_pkg::app_mask_width-1:0] wr_mask
);

  fml_ddr_pkg::port_state_e state;

  // Wrapping lane pointer and beat count within the burst
  logic [$clog2(fml_ddr_pkg::burst_len)-1:0] beat_off;
  logic [$clog2(fml_ddr_pkg::burst_len)-1:0] beat_cnt;
  logic                                      last_beat;
  logic                                      strobe_seen;
  logic                                      rd_arrival;

  // Line returned by the controller
  logic [fml_ddr_pkg::app_data_width-1:0] rd_line;

  assign last_beat   = (beat_cnt == fml_ddr_pkg::burst_len - 1);
  assign strobe_seen = (state == fml_ddr_pkg::port_idle) && fml_stb;
  assign rd_arrival  = app_rd_data_valid && app_rd_data_end;

  // ----------------------------------------
  // Slave FSM
  // ----------------------------------------
  always_ff @(posedge ddr_clk) begin
    if (ddr_rst) begin
      state    <= fml_ddr_pkg::port_idle;
      fml_ack  <= 1'b0;
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      beat_off <= '0;
      beat_cnt <= '0;
    end else begin
      rd_start <= 1'b0;
      wr_start <= 1'b0;
      case (state)
        fml_ddr_pkg::port_idle: begin
          beat_cnt <= '0;
          if (fml_stb) begin
            // Starting beat inside the line
            beat_off <= fml_adr[4:3];
            if (fml_we) begin
              fml_ack <= 1'b1;
              state   <= fml_ddr_pkg::port_wr_beats;
            end else begin
              rd_start <= 1'b1;
              state    <= fml_ddr_pkg::port_rd_wait;
            end
          end
        end
        fml_ddr_pkg::port_wr_beats: begin
          // Ack lasts one cycle, the beats keep arriving
          fml_ack  <= 1'b0;
          beat_off <= beat_off + 1'b1;
          beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) begin
            wr_start <= 1'b1;
            state    <= fml_ddr_pkg::port_wr_wait;
          end
        end
        fml_ddr_pkg::port_wr_wait: begin
          if (wr_done) begin
            state <= fml_ddr_pkg::port_idle;
          end
        end
        fml_ddr_pkg::port_rd_wait: begin
          if (rd_arrival) begin
            fml_ack <= 1'b1;
            state   <= fml_ddr_pkg::port_rd_beats;
          end
        end
        fml_ddr_pkg::port_rd_beats: begin
          beat_off <= beat_off + 1'b1;
          beat_cnt <= beat_cnt + 1'b1;
          if (last_beat) begin
            fml_ack <= 1'b0;
            state   <= fml_ddr_pkg::port_idle;
          end
        end
        default: begin
          state <= fml_ddr_pkg::port_idle;
        end
      endcase
    end
  end

  // ----------------------------------------
  // Line buffers
  // ----------------------------------------
  always_ff @(posedge ddr_clk) begin
    if (strobe_seen) begin
      // Line base, beat bits cleared
      line_addr <= {fml_adr[fml_ddr_pkg::fml_adr_width-1:5], 2'b00};
      if (fml_we) begin
        wr_mask <= {fml_ddr_pkg::burst_len{~fml_sel}};
      end
    end
    if (state == fml_ddr_pkg::port_wr_beats) begin
      wr_line[beat_off*fml_ddr_pkg::beat_width +: fml_ddr_pkg::beat_width] <= fml_di;
    end
    if ((state == fml_ddr_pkg::port_rd_wait) && rd_arrival) begin
      rd_line <= app_rd_data;
    end
  end

  // Beat under the pointer goes straight out
  assign fml_do = rd_line[beat_off*fml_ddr_pkg::beat_width +: fml_ddr_pkg::beat_width];

  // At most one read burst of ack back to back
  ack_run_limit: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    fml_ack [*4] |=> !fml_ack);

  // Controller only returns data for a read we issued
  rd_data_expected: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    app_rd_data_valid |-> (state == fml_ddr_pkg::port_rd_wait));

endmodule

/* logic/fml_ddr3_bridge.sv */
`timescale 1ns/1ns

/* Top of the FML to DDR3 app bridge, all in the ddr_clk domain.
   app_hi_pri and app_sz are tied off by the parent. */
module fml_ddr3_bridge (
  input  logic                                   ddr_clk,
  input  logic                                   ddr_rst,
  // FML slave
  input  logic [fml_ddr_pkg::fml_adr_width-1:0]  fml_adr,
  input  logic                                   fml_stb,
  input  logic                                   fml_we,
  input  logic [fml_ddr_pkg::sel_width-1:0]      fml_sel,
  input  logic [fml_ddr_pkg::beat_width-1:0]     fml_di,
  output logic                                   fml_ack,
  output logic [fml_ddr_pkg::beat_width-1:0]     fml_do,
  // Controller app interface
  input  logic                                   app_rdy,
  input  logic                                   app_wdf_rdy,
  input  logic [fml_ddr_pkg::app_data_width-1:0] app_rd_data,
  input  logic                                   app_rd_data_valid,
  input  logic                                   app_rd_data_end,
  input  logic                                   phy_init_done,
  output logic [fml_ddr_pkg::app_addr_width-1:0] app_addr,
  output fml_ddr_pkg::app_cmd_e                  app_cmd,
  output logic                                   app_en,
  output logic [fml_ddr_pkg::app_data_width-1:0] app_wdf_data,
  output logic [fml_ddr_pkg::app_mask_width-1:0] app_wdf_mask,
  output logic                                   app_wdf_wren,
  output logic                                   app_wdf_end
);

  logic [fml_ddr_pkg::app_addr_width-1:0] line_addr;
  logic                                   rd_start;
  logic                                   wr_start;
  logic [fml_ddr_pkg::app_data_width-1:0] wr_line;
  logic [fml_ddr_pkg::app_mask_width-1:0] wr_mask;
  logic                                   wdf_done;
  logic                                   wr_done;

  fml_burst_port port_i (
    .ddr_clk           (ddr_clk),
    .ddr_rst           (ddr_rst),
    .fml_adr           (fml_adr),
    .fml_stb           (fml_stb),
    .fml_we            (fml_we),
    .fml_sel           (fml_sel),
    .fml_ack           (fml_ack),
    .fml_do            (fml_do),
    .fml_di            (fml_di),
    .app_rd_data       (app_rd_data),
    .app_rd_data_valid (app_rd_data_valid),
    .app_rd_data_end   (app_rd_data_end),
    .wr_done           (wr_done),
    .line_addr         (line_addr),
    .rd_start          (rd_start),
    .wr_start          (wr_start),
    .wr_line           (wr_line),
    .wr_mask           (wr_mask)
  );

  app_cmd_sequencer seq_i (
    .ddr_clk       (ddr_clk),
    .ddr_rst       (ddr_rst),
    .line_addr     (line_addr),
    .rd_start      (rd_start),
    .wr_start      (wr_start),
    .wdf_done      (wdf_done),
    .app_rdy       (app_rdy),
    .phy_init_done (phy_init_done),
    .app_addr      (app_addr),
    .app_cmd       (app_cmd),
    .app_en        (app_en),
    .wr_done       (wr_done)
  );

  app_wdf_writer wdf_i (
    .ddr_clk      (ddr_clk),
    .ddr_rst      (ddr_rst),
    .wr_start     (wr_start),
    .wr_line      (wr_line),
    .wr_mask      (wr_mask),
    .app_wdf_rdy  (app_wdf_rdy),
    .app_wdf_data (app_wdf_data),
    .app_wdf_mask (app_wdf_mask),
    .app_wdf_wren (app_wdf_wren),
    .app_wdf_end  (app_wdf_end),
    .wdf_done     (wdf_done)
  );

endmodule

/* logic/fml_ddr_pkg.sv */
/* Shared widths, burst constants and state/command encodings for the
   FML to DDR3 bridge. Modules reference these by package scope. */
package fml_ddr_pkg;

  // ----------------------------------------
  // FML side
  // ----------------------------------------

  // Byte address from the FML master
  localparam int fml_adr_width = 30;
  // One FML beat and its byte enables
  localparam int beat_width = 64;
  localparam int sel_width = 8;
  // Beats per burst, wrapping inside one line
  localparam int burst_len = 4;

  // ----------------------------------------
  // Controller app side
  // ----------------------------------------

  // Address counted in 64-bit words
  localparam int app_addr_width = 27;
  // One app word holds a whole burst
  localparam int app_data_width = 256;
  localparam int app_mask_width = 32;

  // Command codes on app_cmd
  typedef enum logic [2:0] {
    app_cmd_write = 3'd0,
    app_cmd_read  = 3'd1
  } app_cmd_e;

  // FML slave FSM
  typedef enum logic [2:0] {
    port_idle,
    port_wr_beats,
    port_wr_wait,
    port_rd_wait,
    port_rd_beats
  } port_state_e;

  // Command sequencer FSM
  typedef enum logic [1:0] {
    seq_idle,
    seq_cmd,
    seq_wr_wait
  } seq_state_e;

endpackage

/* sim.f */
logic/fml_ddr_pkg.sv
logic/fml_burst_port.sv
logic/app_cmd_sequencer.sv
logic/app_wdf_writer.sv
logic/fml_ddr3_bridge.sv
verification/mig_app_model.sv
verification/tb_fml_ddr3_bridge.sv

/* verification/mig_app_model.sv */
`timescale 1ns/1ns

/* DDR3 controller app interface model for the bridge testbench. Small line
   memory with random stalls, random read latency and late calibration. */
module mig_app_model (
  input  logic                                   ddr_clk,
  input  logic                                   ddr_rst,
  input  logic [fml_ddr_pkg::app_addr_width-1:0] app_addr,
  input  logic [2:0]                             app_cmd,
  input  logic                                   app_en,
  input  logic [fml_ddr_pkg::app_data_width-1:0] app_wdf_data,
  input  logic [fml_ddr_pkg::app_mask_width-1:0] app_wdf_mask,
  input  logic                                   app_wdf_wren,
  output logic                                   app_rdy,
  output logic                                   app_wdf_rdy,
  output logic [fml_ddr_pkg::app_data_width-1:0] app_rd_data,
  output logic                                   app_rd_data_valid,
  output logic                                   app_rd_data_end,
  output logic                                   phy_init_done
);

  logic [255:0] mem [64];
  logic [255:0] rd_q;
  logic         rdy_q, wdf_rdy_q, valid_q, init_q;
  logic [4:0]   init_cnt;
  logic [3:0]   rd_wait;
  logic         rd_busy;
  logic [5:0]   rd_idx;

  // Write data and command may be taken in either order
  logic         have_data, have_addr;
  logic [255:0] pend_data;
  logic [31:0]  pend_mask;
  logic [5:0]   pend_idx;
  logic         wr_cmd, wdf_take, commit;
  logic [255:0] cur_data;
  logic [31:0]  cur_mask;
  logic [5:0]   cur_idx;

  assign wr_cmd   = app_en && app_rdy && (app_cmd == 3'd0);
  assign wdf_take = app_wdf_wren && app_wdf_rdy;
  assign commit   = (have_data || wdf_take) && (have_addr || wr_cmd);
  assign cur_data = have_data ? pend_data : app_wdf_data;
  assign cur_mask = have_data ? pend_mask : app_wdf_mask;
  assign cur_idx  = have_addr ? pend_idx : app_addr[7:2];

  // Fill depends on line index and word position
  initial begin
    for (int i = 0; i < 64; i++) begin
      for (int w = 0; w < 8; w++) begin
        mem[i][w*32 +: 32] = {8'(i), 8'(w), ~8'(i), 8'h5a};
      end
    end
  end

  always @(posedge ddr_clk) begin
    if (ddr_rst) begin
      init_cnt  <= '0;
      init_q    <= 1'b0;
      rdy_q     <= 1'b0;
      wdf_rdy_q <= 1'b0;
      valid_q   <= 1'b0;
      rd_busy   <= 1'b0;
      have_data <= 1'b0;
      have_addr <= 1'b0;
    end else begin
      rdy_q     <= ($urandom % 4) != 0;
      wdf_rdy_q <= ($urandom % 3) != 0;
      valid_q   <= 1'b0;
      if (init_cnt == 5'd20) begin
        init_q <= 1'b1;
      end else begin
        init_cnt <= init_cnt + 1'b1;
      end
      if (wdf_take) begin
        pend_data <= app_wdf_data;
        pend_mask <= app_wdf_mask;
      end
      if (wr_cmd) begin
        pend_idx <= app_addr[7:2];
      end
      have_data <= (have_data || wdf_take) && !commit;
      have_addr <= (have_addr || wr_cmd) && !commit;
      // Mask bit set means byte kept
      if (commit) begin
        for (int b = 0; b < 32; b++) begin
          if (!cur_mask[b]) begin
            mem[cur_idx][b*8 +: 8] <= cur_data[b*8 +: 8];
          end
        end
      end
      if (app_en && app_rdy && (app_cmd == 3'd1)) begin
        rd_busy <= 1'b1;
        rd_idx  <= app_addr[7:2];
        rd_wait <= 4'(2 + $urandom % 11);
      end else if (rd_busy) begin
        rd_wait <= rd_wait - 1'b1;
        if (rd_wait == 4'd1) begin
          rd_busy <= 1'b0;
          valid_q <= 1'b1;
          rd_q    <= mem[rd_idx];
        end
      end
    end
  end

  // Outputs move a little after the clock edge
  assign #1 app_rdy           = rdy_q;
  assign #1 app_wdf_rdy       = wdf_rdy_q;
  assign #1 app_rd_data       = rd_q;
  assign #1 app_rd_data_valid = valid_q;
  assign #1 app_rd_data_end   = valid_q;
  assign #1 phy_init_done     = init_q;

endmodule

/* verification/tb_fml_ddr3_bridge.sv */
`timescale 1ns/1ns

/* Testbench for the FML to DDR3 bridge. Random write and read-back bursts
   run against the controller model while assertions watch both buses. */
module tb_fml_ddr3_bridge;

  localparam int clk_period = 100;
  localparam int num_pairs  = 30;

  logic                                   ddr_clk, ddr_rst;
  logic [fml_ddr_pkg::fml_adr_width-1:0]  fml_adr;
  logic                                   fml_stb, fml_we, fml_ack;
  logic [fml_ddr_pkg::sel_width-1:0]      fml_sel;
  logic [fml_ddr_pkg::beat_width-1:0]     fml_di, fml_do;
  logic                                   app_rdy, app_wdf_rdy, phy_init_done;
  logic [fml_ddr_pkg::app_data_width-1:0] app_rd_data, app_wdf_data;
  logic                                   app_rd_data_valid, app_rd_data_end;
  logic [fml_ddr_pkg::app_addr_width-1:0] app_addr;
  fml_ddr_pkg::app_cmd_e                  app_cmd;
  logic                                   app_en, app_wdf_wren, app_wdf_end;
  logic [fml_ddr_pkg::app_mask_width-1:0] app_wdf_mask;

  // Expected memory contents and pending bursts
  logic [255:0]          shadow [64];
  fml_ddr_pkg::app_cmd_e exp_cmd_q [$];
  logic [26:0]           exp_addr_q [$];
  logic [255:0]          exp_data_q [$];
  logic [31:0]           exp_mask_q [$];
  logic                  cur_we, strobe_seen;
  logic [255:0]          rd_exp_line;
  logic [1:0]            rd_off;
  int                    rd_beat;

  always #(clk_period / 2) ddr_clk = ~ddr_clk;

  fml_ddr3_bridge fml_ddr3_bridge_i (.*);

  mig_app_model model_i (.*);

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic value_error(input string name, input logic [255:0] got,
                             input logic [255:0] exp);
    stop_on_error($sformatf("error t=%0t %s got %0h expected %0h", $time, name, got, exp));
  endtask

  function automatic logic [255:0] initial_line(input int idx);
    logic [255:0] line;
    for (int w = 0; w < 8; w++) begin
      line[w*32 +: 32] = {8'(idx), 8'(w), ~8'(idx), 8'h5a};
    end
    return line;
  endfunction

  task automatic wait_for_ack();
    do begin
      @(posedge ddr_clk);
      #1;
    end while (!fml_ack);
  endtask

  task automatic write_burst(input logic [29:0] adr, input logic [7:0] sel);
    logic [63:0]  beats [4];
    logic [255:0] line;
    logic [31:0]  mask;
    for (int i = 0; i < 4; i++) begin
      beats[i] = {$urandom, $urandom};
      line[((adr[4:3] + i) % 4) * 64 +: 64] = beats[i];
    end
    // Every lane carries the inverted byte enables
    for (int k = 0; k < 4; k++) begin
      mask[k*8 +: 8] = ~sel;
    end
    for (int b = 0; b < 32; b++) begin
      if (sel[b % 8]) begin
        shadow[adr[10:5]][b*8 +: 8] = line[b*8 +: 8];
      end
    end
    exp_cmd_q.push_back(fml_ddr_pkg::app_cmd_write);
    exp_addr_q.push_back(adr[29:3] & ~27'd3);
    exp_data_q.push_back(line);
    exp_mask_q.push_back(mask);
    cur_we      = 1'b1;
    strobe_seen = 1'b1;
    fml_adr     = adr;
    fml_we      = 1'b1;
    fml_sel     = sel;
    fml_stb     = 1'b1;
    wait_for_ack();
    fml_stb = 1'b0;
    fml_di  = beats[0];
    for (int i = 1; i < 4; i++) begin
      @(posedge ddr_clk);
      #1;
      fml_di = beats[i];
    end
    @(posedge ddr_clk);
    #1;
  endtask

  task automatic read_burst(input logic [29:0] adr);
    exp_cmd_q.push_back(fml_ddr_pkg::app_cmd_read);
    exp_addr_q.push_back(adr[29:3] & ~27'd3);
    rd_exp_line = shadow[adr[10:5]];
    rd_off      = adr[4:3];
    rd_beat     = 0;
    cur_we      = 1'b0;
    fml_adr     = adr;
    fml_we      = 1'b0;
    fml_stb     = 1'b1;
    wait_for_ack();
    fml_stb = 1'b0;
    do begin
      @(posedge ddr_clk);
      #1;
    end while (fml_ack);
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  quiet_after_reset: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    !strobe_seen |-> (!fml_ack && !app_en && !app_wdf_wren))
    else stop_on_error("bridge active after reset before any strobe");
  no_cmd_before_init: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    !phy_init_done |-> !app_en)
    else stop_on_error("app_en raised before calibration finished");
  write_ack_once: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (cur_we && fml_ack) |=> !fml_ack)
    else stop_on_error("fml_ack longer than one cycle on a write burst");
  read_ack_four: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (!cur_we && $rose(fml_ack)) |-> fml_ack [*4] ##1 !fml_ack)
    else stop_on_error("fml_ack not high for exactly four cycles on a read burst");
  cmd_stable: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (app_en && !app_rdy) |=> (app_en && $stable(app_addr) && $stable(app_cmd)))
    else stop_on_error("command changed while app_rdy was low");
  wdf_stable: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    (app_wdf_wren && !app_wdf_rdy) |=>
      (app_wdf_wren && $stable(app_wdf_data) && $stable(app_wdf_mask)))
    else stop_on_error("write data changed while app_wdf_rdy was low");
  // One app word per burst, so the end flag always goes with the strobe
  wdf_end_with_wren: assert property (@(posedge ddr_clk) disable iff (ddr_rst)
    app_wdf_end == app_wdf_wren)
    else stop_on_error("app_wdf_end does not match app_wdf_wren");

  always @(posedge ddr_clk) begin
    if (!ddr_rst && app_en && app_rdy) begin
      assert (exp_cmd_q.size() > 0) else stop_on_error("command accepted with no burst pending");
      assert (app_cmd == exp_cmd_q[0]) else value_error("app_cmd", app_cmd, exp_cmd_q[0]);
      assert (app_addr == exp_addr_q[0]) else value_error("app_addr", app_addr, exp_addr_q[0]);
      void'(exp_cmd_q.pop_front());
      void'(exp_addr_q.pop_front());
    end
    if (!ddr_rst && app_wdf_wren && app_wdf_rdy) begin
      assert (exp_data_q.size() > 0)
        else stop_on_error("write data accepted with no write pending");
      assert (app_wdf_data == exp_data_q[0])
        else value_error("app_wdf_data", app_wdf_data, exp_data_q[0]);
      assert (app_wdf_mask == exp_mask_q[0])
        else value_error("app_wdf_mask", app_wdf_mask, exp_mask_q[0]);
      void'(exp_data_q.pop_front());
      void'(exp_mask_q.pop_front());
    end
  end

  // Read beats wrap from the starting lane
  always @(posedge ddr_clk) begin : read_beat_check
    logic [63:0] exp_beat;
    if (!ddr_rst && fml_ack && !cur_we) begin
      exp_beat = rd_exp_line[((rd_off + rd_beat) % 4) * 64 +: 64];
      assert (fml_do == exp_beat) else value_error("fml_do", fml_do, exp_beat);
      rd_beat = rd_beat + 1;
    end
  end

  // Allows 400 cycles per burst
  initial begin : watchdog
    repeat ((2 * num_pairs + 1) * 400) @(posedge ddr_clk);
    stop_on_error("watchdog expired before all bursts finished");
  end

  initial begin : main
    logic [29:0] adr;
    void'($urandom(32'h9f60_db14));
    ddr_clk     = 1'b0;
    ddr_rst     = 1'b1;
    fml_adr     = '0;
    fml_stb     = 1'b0;
    fml_we      = 1'b0;
    fml_sel     = '0;
    fml_di      = '0;
    cur_we      = 1'b0;
    strobe_seen = 1'b0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = initial_line(i);
    end
    repeat (8) @(posedge ddr_clk);
    #1;
    ddr_rst = 1'b0;
    // A few quiet cycles before the first strobe
    repeat (4) @(posedge ddr_clk);
    #1;
    repeat (num_pairs) begin
      adr      = 30'($urandom);
      adr[2:0] = 3'b000;
      write_burst(adr, 8'($urandom));
      // Read back the same line or another one
      adr[4:3] = 2'($urandom);
      if ($urandom % 2) begin
        adr[10:5] = 6'($urandom);
      end
      read_burst(adr);
    end
    repeat (4) @(posedge ddr_clk);
    if (exp_cmd_q.size() == 0 && exp_data_q.size() == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_on_error("bursts still waiting for acceptance at end of run");
    end
  end

endmodule
